// ==== vlog.f ====
armCorePkg.sv
registerFile.sv
decodeStage.sv
aluUnit.sv
executeStage.sv
memAccessStage.sv
armCore.sv
clockGen.sv
tbArmCore.sv

// ==== tbArmCore.sv ====
module tbArmCore;

   localparam int clkPeriod = 40;
   localparam int resetCycles = 8;
   localparam logic [31:0] nopWord = 32'h0800_0000;

   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] addr;
      logic [31:0] data;
      logic [2:0] test;
   } storeRec;

   logic clk;
   logic reset;
   logic [31:0] inst;
   logic [31:0] readData;
   logic [31:0] pc;
   logic [31:0] memAddr;
   logic [31:0] writeData;
   logic memWrite;
   logic memRead;

   logic [31:0] imem [2048];
   logic [31:0] dmem [1024];
   logic [31:0] mregs [16];
   logic [3:0] mflags;
   logic [15:0] lfsr = 16'd42596;
   storeRec expStores [$];
   bit loadAt [2048];
   int progLen = 0;
   int storeOff = 'h100;
   int errs [1:5] = '{default: 0};
   int pending [1:5] = '{default: 0};
   string testNames [1:5] = '{"reset and pc", "data processing", "store timing",
                              "flags and conditions", "loads"};
   bit built = 1'b0;
   bit havePrev = 1'b0;
   logic [31:0] prevPc;

   clockGen #(.period(clkPeriod), .resetCycles(resetCycles)) clocks (
      .o_clk(clk),
      .o_reset(reset)
   );

   armCore uut (
      .clk(clk),
      .reset(reset),
      .i_inst(inst),
      .i_readData(readData),
      .o_pc(pc),
      .o_memAddr(memAddr),
      .o_memWrite(memWrite),
      .o_memRead(memRead),
      .o_writeData(writeData)
   );

   // fetch past the program end sees no-ops
   assign inst = (pc[31:2] < progLen) ? imem[pc[12:2]] : nopWord;

   // read data lags the address by one cycle
   always @(posedge clk) begin
      if (memWrite) begin
         dmem[memAddr[11:2]] <= writeData;
      end
      readData <= dmem[memAddr[11:2]];
   end

   function automatic logic [31:0] fillWord(input logic [31:0] addr);
      return (addr * 32'h9E37_79B1) ^ 32'h0F1E_C3A5;
   endfunction

   // galois lfsr stepped once per bit handed out
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic bit condHolds(input logic [3:0] cond, input logic [3:0] f);
      logic n;
      logic z;
      logic c;
      logic v;
      {n, z, c, v} = f;
      case (cond)
         armCorePkg::condEq: return z;
         armCorePkg::condNe: return !z;
         armCorePkg::condCs: return c;
         armCorePkg::condCc: return !c;
         armCorePkg::condMi: return n;
         armCorePkg::condPl: return !n;
         armCorePkg::condVs: return v;
         armCorePkg::condVc: return !v;
         armCorePkg::condHi: return c && !z;
         armCorePkg::condLs: return !c || z;
         armCorePkg::condGe: return n == v;
         armCorePkg::condLt: return n != v;
         armCorePkg::condGt: return !z && (n == v);
         armCorePkg::condLe: return z || (n != v);
         default: return 1'b1;
      endcase
   endfunction

   function automatic logic [31:0] encDp(input logic [3:0] cond, input logic [3:0] cmd,
         input logic s, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm,
         input logic [4:0] sh);
      return {cond, 3'b000, cmd, s, rn, rd, sh, 3'b000, rm};
   endfunction

   function automatic logic [31:0] encMem(input logic load, input logic [3:0] rd,
         input logic [3:0] rn, input logic [11:0] off);
      return {4'hE, 7'b0101100, load, rn, rd, off};
   endfunction

   // reference model of one data-processing instruction
   task automatic modelDp(input logic [3:0] cond, input logic [3:0] cmd, input logic s,
         input logic [3:0] rd, input logic [31:0] a, input logic [31:0] b);
      logic [32:0] wide;
      logic [31:0] r;
      logic c;
      logic v;
      c = mflags[1];
      v = mflags[0];
      case (cmd)
         armCorePkg::cmdAnd: r = a & b;
         armCorePkg::cmdEor: r = a ^ b;
         armCorePkg::cmdOrr: r = a | b;
         armCorePkg::cmdMov: r = b;
         armCorePkg::cmdAdd, armCorePkg::cmdAdc: begin
            wide = {1'b0, a} + {1'b0, b} + ((cmd == armCorePkg::cmdAdc) ? mflags[1] : 1'b0);
            r = wide[31:0];
            c = wide[32];
            v = (a[31] == b[31]) && (r[31] != a[31]);
         end
         default: begin
            // carry is the inverse of borrow
            r = a - b;
            c = (a >= b);
            v = (a[31] != b[31]) && (r[31] != a[31]);
         end
      endcase
      if (condHolds(cond, mflags)) begin
         if (s) begin
            mflags = {r[31], r == 32'h0, c, v};
         end
         if (cmd != armCorePkg::cmdCmp) begin
            mregs[rd] = r;
         end
      end
   endtask

   // three no-ops keep every consumer clear of its producer
   task automatic emit(input logic [31:0] word);
      imem[progLen] = word;
      for (int i = 1; i <= 3; i++) begin
         imem[progLen + i] = nopWord;
      end
      progLen += 4;
   endtask

   task automatic dp(input logic [3:0] cond, input logic [3:0] cmd, input logic s,
         input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm,
         input logic [4:0] sh);
      modelDp(cond, cmd, s, rd, mregs[rn], mregs[rm] << sh);
      emit(encDp(cond, cmd, s, rd, rn, rm, sh));
   endtask

   task automatic movImm(input logic [3:0] cond, input logic [3:0] rd, input logic [7:0] imm);
      modelDp(cond, armCorePkg::cmdMov, 1'b0, rd, 32'h0, {{24{imm[7]}}, imm});
      emit({cond, 3'b001, armCorePkg::cmdMov, 1'b0, 4'h0, rd, 4'h0, imm});
   endtask

   task automatic str(input logic [3:0] rd, input logic [3:0] rn, input int test);
      storeRec rec;
      rec.pc = 32'(progLen * 4);
      rec.addr = mregs[rn] + 32'(storeOff);
      rec.data = mregs[rd];
      rec.test = 3'(test);
      expStores.push_back(rec);
      pending[test]++;
      emit(encMem(1'b0, rd, rn, 12'(storeOff)));
      storeOff += 4;
   endtask

   task automatic ldr(input logic [3:0] rd, input logic [3:0] rn, input logic [11:0] off);
      mregs[rd] = fillWord(mregs[rn] + 32'(off));
      loadAt[progLen] = 1'b1;
      emit(encMem(1'b1, rd, rn, off));
   endtask

   task automatic buildProgram();
      logic [3:0] cmds [5];
      logic [3:0] cmd;
      logic [3:0] rd;
      logic [3:0] rn;
      logic [3:0] rm;
      logic [4:0] sh;
      cmds = '{armCorePkg::cmdAnd, armCorePkg::cmdEor, armCorePkg::cmdSub,
               armCorePkg::cmdAdd, armCorePkg::cmdOrr};
      for (int i = 0; i < 16; i++) begin
         mregs[i] = '0;
      end
      mflags = '0;
      for (int k = 1; k <= 8; k++) begin
         movImm(armCorePkg::condAl, 4'(k), 8'(randBits(8)));
         str(4'(k), 4'd13, 2);
      end
      for (int k = 0; k < 12; k++) begin
         cmd = cmds[randBits(3) % 5];
         rd = 4'(1 + randBits(3));
         rn = 4'(1 + randBits(3));
         rm = 4'(1 + randBits(3));
         sh = 5'(randBits(5));
         dp(armCorePkg::condAl, cmd, 1'b0, rd, rn, rm, sh);
         str(rd, 4'd13, 2);
      end
      // round 0 compares a register with itself
      for (int r = 0; r < 6; r++) begin
         movImm(armCorePkg::condAl, 4'd6, 8'(randBits(8)));
         movImm(armCorePkg::condAl, 4'd7, 8'(randBits(8)));
         sh = (r == 0) ? 5'd0 : 5'(randBits(5));
         rm = (r == 0) ? 4'd6 : 4'd7;
         cmds[0] = (r % 3 == 0) ? armCorePkg::cmdCmp :
                   (r % 3 == 1) ? armCorePkg::cmdSub : armCorePkg::cmdAdd;
         dp(armCorePkg::condAl, cmds[0], 1'b1, 4'd8, 4'd6, rm, sh);
         str(4'd8, 4'd13, 4);
         dp(armCorePkg::condAl, armCorePkg::cmdAdc, 1'b0, 4'd9, 4'd6, 4'd7, 5'(randBits(5)));
         str(4'd9, 4'd13, 4);
         for (int c = 0; c < 15; c++) begin
            movImm(armCorePkg::condAl, 4'd5, 8'd0);
            movImm(4'(c), 4'd5, 8'(c + 1));
            str(4'd5, 4'd13, 4);
         end
      end
      movImm(armCorePkg::condAl, 4'd11, 8'h40);
      for (int k = 0; k < 6; k++) begin
         ldr(4'd10, 4'd11, 12'(32'h800 + randBits(6) * 4));
         str(4'd10, 4'd13, 5);
      end
   endtask

   task automatic logFail(input int test, input string msg);
      errs[test]++;
      $display("FAILED at time %0t: %s", $time, msg);
   endtask

   task automatic reportTest(input int t);
      $display("test %0d, %s: %0d errors", t, testNames[t], errs[t]);
   endtask

   always @(negedge clk) begin
      storeRec rec;
      if (reset) begin
         assert (pc == 32'h0 && !memWrite && !memRead)
            else logFail(1, $sformatf("ports not idle in reset, pc %h", pc));
         havePrev = 1'b0;
      end else begin
         assert (havePrev ? (pc == prevPc + 32'd4) : (pc == 32'h0))
            else logFail(1, $sformatf("pc %h follows %h", pc, prevPc));
         prevPc = pc;
         havePrev = 1'b1;
         // a load drives the read strobe three fetches after its own
         assert (memRead == (pc >= 32'd12 && loadAt[(pc - 32'd12) >> 2]))
            else logFail(5, $sformatf("read strobe %b at pc %h", memRead, pc));
         if (memWrite && expStores.size() == 0) begin
            errs[3]++;
            $display("an unexpected store to address %h appeared at time %0t", memAddr, $time);
         end else if (memWrite) begin
            rec = expStores.pop_front();
            assert (pc == rec.pc + 32'd12 && memAddr == rec.addr)
               else logFail(3, $sformatf("store at pc %h addr %h, expected pc %h addr %h",
                                         pc, memAddr, rec.pc + 32'd12, rec.addr));
            assert (writeData == rec.data)
               else logFail(rec.test, $sformatf("stored %h to %h, expected %h",
                                                writeData, memAddr, rec.data));
            pending[rec.test]--;
            if (pending[rec.test] == 0) begin
               reportTest(rec.test);
            end
         end
      end
   end

   initial begin
      int total;
      int failed;
      for (int i = 0; i < 1024; i++) begin
         dmem[i] <= fillWord(32'(i * 4));
      end
      readData <= '0;
      buildProgram();
      built = 1'b1;
      @(negedge reset);
      while (expStores.size() != 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      reportTest(1);
      reportTest(3);
      total = 0;
      failed = 0;
      for (int t = 1; t <= 5; t++) begin
         total += errs[t];
         failed += (errs[t] != 0);
      end
      $display("5 tests, %0d passed, %0d failed, %0d errors", 5 - failed, failed, total);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // watchdog sized from the program length
   initial begin
      wait (built);
      #((progLen + resetCycles + 20) * clkPeriod);
      $display("timeout with %0d expected stores never seen", expStores.size());
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== clockGen.sv ====
module clockGen #(
   parameter int period = 40,
   parameter int resetCycles = 8
) (
   output logic o_clk,
   output logic o_reset
);

   initial begin
      o_clk = 1'b0;
      forever #(period / 2) o_clk = ~o_clk;
   end

   // reset drops on a rising edge
   initial begin
      o_reset <= 1'b1;
      repeat (resetCycles) @(posedge o_clk);
      o_reset <= 1'b0;
   end

endmodule

// ==== armCore.sv ====
module armCore (
   input  logic clk,
   input  logic reset,
   input  logic [armCorePkg::dataWidth-1:0] i_inst,
   input  logic [armCorePkg::dataWidth-1:0] i_readData,
   output logic [armCorePkg::dataWidth-1:0] o_pc,
   output logic [armCorePkg::dataWidth-1:0] o_memAddr,
   output logic o_memWrite,
   output logic o_memRead,
   output logic [armCorePkg::dataWidth-1:0] o_writeData
);

   logic [armCorePkg::regAddrWidth-1:0] readAddrA;
   logic [armCorePkg::regAddrWidth-1:0] readAddrB;
   logic [armCorePkg::dataWidth-1:0] readDataA;
   logic [armCorePkg::dataWidth-1:0] readDataB;
   armCorePkg::idExPayload idEx;
   armCorePkg::exMemPayload exMem;
   armCorePkg::writeBack wbBus;

   decodeStage decode (
      .clk(clk),
      .reset(reset),
      .i_inst(i_inst),
      .i_readDataA(readDataA),
      .i_readDataB(readDataB),
      .o_pc(o_pc),
      .o_readAddrA(readAddrA),
      .o_readAddrB(readAddrB),
      .o_idEx(idEx)
   );

   registerFile regFile (
      .clk(clk),
      .reset(reset),
      .i_readAddrA(readAddrA),
      .i_readAddrB(readAddrB),
      .i_writeBack(wbBus),
      .o_readDataA(readDataA),
      .o_readDataB(readDataB)
   );

   executeStage execute (
      .clk(clk),
      .reset(reset),
      .i_idEx(idEx),
      .o_exMem(exMem)
   );

   memAccessStage memAccess (
      .clk(clk),
      .reset(reset),
      .i_exMem(exMem),
      .i_readData(i_readData),
      .o_memAddr(o_memAddr),
      .o_memWrite(o_memWrite),
      .o_memRead(o_memRead),
      .o_writeData(o_writeData),
      .o_writeBack(wbBus)
   );

endmodule

// ==== memAccessStage.sv ====
module memAccessStage (
   input  logic clk,
   input  logic reset,
   input  armCorePkg::exMemPayload i_exMem,
   input  logic [armCorePkg::dataWidth-1:0] i_readData,
   output logic [armCorePkg::dataWidth-1:0] o_memAddr,
   output logic o_memWrite,
   output logic o_memRead,
   output logic [armCorePkg::dataWidth-1:0] o_writeData,
   output armCorePkg::writeBack o_writeBack
);

   armCorePkg::writeBack memWb;
   logic memToRegWb;

   assign o_memAddr = i_exMem.aluResult;
   assign o_memWrite = i_exMem.memWrite;
   assign o_memRead = i_exMem.memRead;
   assign o_writeData = i_exMem.storeData;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         memWb <= '0;
         memToRegWb <= 1'b0;
      end else begin
         memWb.regWrite <= i_exMem.regWrite;
         memWb.destReg <= i_exMem.destReg;
         memWb.value <= i_exMem.aluResult;
         memToRegWb <= i_exMem.memToReg;
      end
   end

   // load data arrives one cycle after the read strobe
   always_comb begin
      o_writeBack = memWb;
      if (memToRegWb) begin
         o_writeBack.value = i_readData;
      end
   end

endmodule

// ==== executeStage.sv ====
module executeStage (
   input  logic clk,
   input  logic reset,
   input  armCorePkg::idExPayload i_idEx,
   output armCorePkg::exMemPayload o_exMem
);

   logic [armCorePkg::dataWidth-1:0] aluB;
   logic [armCorePkg::dataWidth-1:0] aluResult;
   armCorePkg::nzcvFlags flags;
   armCorePkg::nzcvFlags aluFlags;
   armCorePkg::nzcvFlags nextFlags;
   logic condPass;
   logic isArith;

   assign aluB = i_idEx.useImm ? i_idEx.immValue : (i_idEx.operandB << i_idEx.shiftAmount);

   aluUnit alu (
      .i_cmd(i_idEx.cmd),
      .i_a(i_idEx.operandA),
      .i_b(aluB),
      .i_carryIn(flags.carry),
      .o_result(aluResult),
      .o_flags(aluFlags)
   );

   always_comb begin
      case (i_idEx.cond)
         armCorePkg::condEq: condPass = flags.zero;
         armCorePkg::condNe: condPass = !flags.zero;
         armCorePkg::condCs: condPass = flags.carry;
         armCorePkg::condCc: condPass = !flags.carry;
         armCorePkg::condMi: condPass = flags.negative;
         armCorePkg::condPl: condPass = !flags.negative;
         armCorePkg::condVs: condPass = flags.overflow;
         armCorePkg::condVc: condPass = !flags.overflow;
         armCorePkg::condHi: condPass = flags.carry && !flags.zero;
         armCorePkg::condLs: condPass = !flags.carry || flags.zero;
         armCorePkg::condGe: condPass = (flags.negative == flags.overflow);
         armCorePkg::condLt: condPass = (flags.negative != flags.overflow);
         armCorePkg::condGt: condPass = !flags.zero && (flags.negative == flags.overflow);
         armCorePkg::condLe: condPass = flags.zero || (flags.negative != flags.overflow);
         armCorePkg::condAl: condPass = 1'b1;
         default: condPass = 1'b0;
      endcase
   end

   // logical ops keep V here and get C back from the alu unchanged
   assign isArith = i_idEx.cmd inside {armCorePkg::cmdSub, armCorePkg::cmdAdd,
                                       armCorePkg::cmdAdc, armCorePkg::cmdCmp};

   always_comb begin
      nextFlags = aluFlags;
      if (!isArith) begin
         nextFlags.overflow = flags.overflow;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else if (condPass && i_idEx.flagWrite) begin
         flags <= nextFlags;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_exMem <= '0;
      end else begin
         o_exMem.regWrite <= i_idEx.regWrite && condPass;
         o_exMem.memWrite <= i_idEx.memWrite && condPass;
         o_exMem.memRead <= i_idEx.memRead && condPass;
         o_exMem.memToReg <= i_idEx.memToReg;
         o_exMem.destReg <= i_idEx.destReg;
         o_exMem.aluResult <= aluResult;
         o_exMem.storeData <= i_idEx.operandB;
      end
   end

endmodule

// ==== aluUnit.sv ====
module aluUnit (
   input  armCorePkg::aluCmd i_cmd,
   input  logic [armCorePkg::dataWidth-1:0] i_a,
   input  logic [armCorePkg::dataWidth-1:0] i_b,
   input  logic i_carryIn,
   output logic [armCorePkg::dataWidth-1:0] o_result,
   output armCorePkg::nzcvFlags o_flags
);

   localparam int msb = armCorePkg::dataWidth - 1;

   logic subtract;
   logic addCarryIn;
   logic [armCorePkg::dataWidth-1:0] addB;
   logic [armCorePkg::dataWidth:0] sum;

   // one adder for add, adc, sub and cmp
   assign subtract = (i_cmd == armCorePkg::cmdSub) || (i_cmd == armCorePkg::cmdCmp);
   assign addB = subtract ? ~i_b : i_b;
   assign addCarryIn = subtract || ((i_cmd == armCorePkg::cmdAdc) && i_carryIn);
   assign sum = {1'b0, i_a} + {1'b0, addB} + addCarryIn;

   always_comb begin
      o_flags.carry = i_carryIn;
      o_flags.overflow = 1'b0;
      case (i_cmd)
         armCorePkg::cmdAnd: o_result = i_a & i_b;
         armCorePkg::cmdEor: o_result = i_a ^ i_b;
         armCorePkg::cmdOrr: o_result = i_a | i_b;
         armCorePkg::cmdMov: o_result = i_b;
         armCorePkg::cmdSub,
         armCorePkg::cmdAdd,
         armCorePkg::cmdAdc,
         armCorePkg::cmdCmp: begin
            o_result = sum[msb:0];
            // carry set means no borrow on subtract
            o_flags.carry = sum[armCorePkg::dataWidth];
            o_flags.overflow = (i_a[msb] == addB[msb]) && (sum[msb] != i_a[msb]);
         end
         default: o_result = '0;
      endcase
      o_flags.negative = o_result[msb];
      o_flags.zero = (o_result == '0);
   end

endmodule

// ==== decodeStage.sv ====
module decodeStage (
   input  logic clk,
   input  logic reset,
   input  logic [armCorePkg::dataWidth-1:0] i_inst,
   input  logic [armCorePkg::dataWidth-1:0] i_readDataA,
   input  logic [armCorePkg::dataWidth-1:0] i_readDataB,
   output logic [armCorePkg::dataWidth-1:0] o_pc,
   output logic [armCorePkg::regAddrWidth-1:0] o_readAddrA,
   output logic [armCorePkg::regAddrWidth-1:0] o_readAddrB,
   output armCorePkg::idExPayload o_idEx
);

   logic [armCorePkg::dataWidth-1:0] instD;
   logic instValid;
   logic [1:0] opField;
   logic immBit;
   logic sBit;
   logic loadBit;
   logic isDataProc;
   logic isMemory;
   armCorePkg::aluCmd cmdField;
   armCorePkg::idExPayload idNext;

   // fetch with a pc that only steps forward
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_pc <= '0;
         instValid <= 1'b0;
      end else begin
         o_pc <= o_pc + armCorePkg::pcStep;
         instValid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      instD <= i_inst;
   end

   assign opField = instD[27:26];
   assign immBit = instD[25];
   assign sBit = instD[20];
   assign loadBit = instD[20];
   assign cmdField = armCorePkg::aluCmd'(instD[24:21]);

   // opcodes 10 and 11 fall through both and become bubbles
   assign isDataProc = instValid && (opField == armCorePkg::opDataProc);
   assign isMemory = instValid && (opField == armCorePkg::opMemory);

   assign o_readAddrA = instD[19:16];
   // stores read Rd as the data to write
   assign o_readAddrB = isMemory ? instD[15:12] : instD[3:0];

   always_comb begin
      idNext = '0;
      idNext.cmd = cmdField;
      idNext.cond = armCorePkg::condCode'(instD[31:28]);
      idNext.shiftAmount = instD[11:7];
      idNext.destReg = instD[15:12];
      idNext.operandA = i_readDataA;
      idNext.operandB = i_readDataB;
      idNext.immValue = {{(armCorePkg::dataWidth - 8){instD[7]}}, instD[7:0]};

      if (isDataProc) begin
         idNext.regWrite = (cmdField != armCorePkg::cmdCmp);
         idNext.flagWrite = sBit || (cmdField == armCorePkg::cmdCmp);
         idNext.useImm = immBit;
      end else if (isMemory) begin
         // address is base plus unsigned offset
         idNext.cmd = armCorePkg::cmdAdd;
         idNext.useImm = 1'b1;
         idNext.immValue = {{(armCorePkg::dataWidth - 12){1'b0}}, instD[11:0]};
         idNext.memRead = loadBit;
         idNext.memWrite = !loadBit;
         idNext.regWrite = loadBit;
         idNext.memToReg = loadBit;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_idEx <= '0;
      end else begin
         o_idEx <= idNext;
      end
   end

endmodule

// ==== registerFile.sv ====
module registerFile (
   input  logic clk,
   input  logic reset,
   input  logic [armCorePkg::regAddrWidth-1:0] i_readAddrA,
   input  logic [armCorePkg::regAddrWidth-1:0] i_readAddrB,
   input  armCorePkg::writeBack i_writeBack,
   output logic [armCorePkg::dataWidth-1:0] o_readDataA,
   output logic [armCorePkg::dataWidth-1:0] o_readDataB
);

   logic [armCorePkg::dataWidth-1:0] regs [armCorePkg::regCount];
   logic bypassA;
   logic bypassB;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < armCorePkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (i_writeBack.regWrite) begin
         regs[i_writeBack.destReg] <= i_writeBack.value;
      end
   end

   // writeback in this cycle is visible to decode right away
   assign bypassA = i_writeBack.regWrite && (i_writeBack.destReg == i_readAddrA);
   assign bypassB = i_writeBack.regWrite && (i_writeBack.destReg == i_readAddrB);

   assign o_readDataA = bypassA ? i_writeBack.value : regs[i_readAddrA];
   assign o_readDataB = bypassB ? i_writeBack.value : regs[i_readAddrB];

endmodule

// ==== armCorePkg.sv ====
package armCorePkg;

   localparam int dataWidth = 32;
   localparam int regAddrWidth = 4;
   localparam int regCount = 16;
   localparam int pcStep = 4;

   // instruction class in bits 27:26
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory = 2'b01;

   // ARM data-processing command field
   typedef enum logic [3:0] {
      cmdAnd = 4'b0000,
      cmdEor = 4'b0001,
      cmdSub = 4'b0010,
      cmdAdd = 4'b0100,
      cmdAdc = 4'b0101,
      cmdCmp = 4'b1010,
      cmdOrr = 4'b1100,
      cmdMov = 4'b1101
   } aluCmd;

   typedef enum logic [3:0] {
      condEq = 4'd0,
      condNe = 4'd1,
      condCs = 4'd2,
      condCc = 4'd3,
      condMi = 4'd4,
      condPl = 4'd5,
      condVs = 4'd6,
      condVc = 4'd7,
      condHi = 4'd8,
      condLs = 4'd9,
      condGe = 4'd10,
      condLt = 4'd11,
      condGt = 4'd12,
      condLe = 4'd13,
      condAl = 4'd14
   } condCode;

   typedef struct packed {
      logic negative;
      logic zero;
      logic carry;
      logic overflow;
   } nzcvFlags;

   // decode to execute
   typedef struct packed {
      logic regWrite;
      logic memWrite;
      logic memRead;
      logic memToReg;
      logic flagWrite;
      logic useImm;
      aluCmd cmd;
      condCode cond;
      logic [4:0] shiftAmount;
      logic [regAddrWidth-1:0] destReg;
      logic [dataWidth-1:0] operandA;
      logic [dataWidth-1:0] operandB;
      logic [dataWidth-1:0] immValue;
   } idExPayload;

   // execute to memory
   typedef struct packed {
      logic regWrite;
      logic memWrite;
      logic memRead;
      logic memToReg;
      logic [regAddrWidth-1:0] destReg;
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] storeData;
   } exMemPayload;

   typedef struct packed {
      logic regWrite;
      logic [regAddrWidth-1:0] destReg;
      logic [dataWidth-1:0] value;
   } writeBack;

endpackage
